/* design/sd_readout_pkg.sv */
package sd_readout_pkg;

    // ==================================================
    // Data path
    // ==================================================
    localparam int WORD_W = 16;

    // One SD data-in word, also one readout word
    typedef logic [WORD_W-1:0] word_t;

    // ==================================================
    // CMD6 status block geometry
    // ==================================================
    // 512-bit status block arrives as 32 words
    localparam int BLOCK_WORDS      = 32;
    localparam int ACCESS_MODE_WORD = 8;    // Zero-based word index
    localparam int ACCESS_MODE_LSB  = 8;    // Nibble position inside that word

    typedef logic [3:0] access_mode_t;

    // ==================================================
    // FIFO sizing
    // ==================================================
    localparam int FIFO_DEPTH_DEFAULT  = 64;

    // Burst length, doubles as the FIFO read threshold
    localparam int BURST_WORDS_DEFAULT = 16;

endpackage

/* design/msg_pkg.sv */
package msg_pkg;

    // ==================================================
    // Command opcodes
    // ==================================================
    // Codes 5 to 7 are undefined and get an error response
    typedef enum logic [2:0] {
        OP_NOP     = 3'd0,
        OP_ECHO    = 3'd1,
        OP_LED_SET = 3'd2,
        OP_STATUS  = 3'd3,
        OP_READOUT = 3'd4
    } opcode_t;

    // ==================================================
    // Message and response fields
    // ==================================================
    localparam int MSG_ARG_W = 24;
    localparam int RESP_W    = 32;
    localparam int LED_W     = 4;      // Low bits of the LEDSet argument

    // Completed CMD6 blocks, wraps
    localparam int BLOCK_CNT_W = 8;

    // ==================================================
    // Status response layout
    // ==================================================
    // [3:0]   access mode nibble
    // [11:4]  block count
    // [12+:n] FIFO level, width set by the FIFO depth
    // Bits above the level read as zero
    localparam int STATUS_MODE_LSB   = 0;
    localparam int STATUS_BLOCKS_LSB = 4;
    localparam int STATUS_LEVEL_LSB  = 12;

endpackage

/* design/dat_in_capture.sv */
module dat_in_capture (
    input  logic                             sd_datInWrite_clk,
    input  logic                             spi_rst_,
    input  logic                             dat_in_start,
    input  logic                             dat_in_trigger,
    input  sd_readout_pkg::word_t            dat_in_data,
    output logic                             dat_in_ready,
    input  logic                             full,
    output logic                             push,
    output sd_readout_pkg::word_t            push_data,
    output sd_readout_pkg::access_mode_t     access_mode,
    output logic [msg_pkg::BLOCK_CNT_W-1:0]  block_count
);
    localparam int IDX_W = $clog2(sd_readout_pkg::BLOCK_WORDS);

    typedef enum logic {
        CAP_IDLE,   // No block started since reset
        CAP_BLOCK
    } capture_state_t;

    capture_state_t   state;
    logic [IDX_W-1:0] word_idx;
    logic [IDX_W-1:0] cur_idx;
    logic             counting;

    // Source is held off only by a full FIFO
    assign dat_in_ready = !full;
    assign push         = dat_in_trigger && dat_in_ready;
    assign push_data    = dat_in_data;

    // A word accepted with the start pulse is word 0
    assign cur_idx  = dat_in_start ? '0 : word_idx;
    assign counting = dat_in_start || (state == CAP_BLOCK);

    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            state       <= CAP_IDLE;
            word_idx    <= '0;
            access_mode <= '0;
            block_count <= '0;
        end else begin
            if (dat_in_start) begin
                state    <= CAP_BLOCK;
                word_idx <= '0;
            end
            if (push && counting) begin
                if (cur_idx == IDX_W'(sd_readout_pkg::ACCESS_MODE_WORD)) begin
                    access_mode <= dat_in_data[sd_readout_pkg::ACCESS_MODE_LSB +:
                                               $bits(sd_readout_pkg::access_mode_t)];
                end
                if (cur_idx == IDX_W'(sd_readout_pkg::BLOCK_WORDS - 1)) begin
                    block_count <= block_count + 1'b1;  // Wraps at 256
                    word_idx    <= '0;                  // Next block follows directly
                end else begin
                    word_idx <= cur_idx + 1'b1;
                end
            end
        end
    end

    // SD controller presents a clean word whenever it offers one
    a_dat_in_known: assert property (@(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        dat_in_trigger |-> !$isunknown(dat_in_data));

endmodule

/* design/readout_fifo.sv */
module readout_fifo #(
    parameter int FIFO_DEPTH  = sd_readout_pkg::FIFO_DEPTH_DEFAULT,
    parameter int BURST_WORDS = sd_readout_pkg::BURST_WORDS_DEFAULT
) (
    input  logic                              sd_datInWrite_clk,
    input  logic                              spi_rst_,
    input  logic                              push,
    input  sd_readout_pkg::word_t             push_data,
    input  logic                              pop,
    output sd_readout_pkg::word_t             pop_data,
    output logic                              full,
    output logic [$clog2(FIFO_DEPTH+1)-1:0]   level,
    output logic                              burst_ready
);
    localparam int LVL_W = $clog2(FIFO_DEPTH + 1);
    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    sd_readout_pkg::word_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr_next;
    logic [PTR_W-1:0] rd_ptr_next;

    // ==================================================
    // Pointers and fill level
    // ==================================================
    // Explicit wrap, depth need not be a power of two
    assign wr_ptr_next = (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
    assign rd_ptr_next = (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr_next;
            end
            if (pop) begin
                rd_ptr <= rd_ptr_next;
            end
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;    // Idle, or push and pop together
            endcase
        end
    end

    // ==================================================
    // Storage
    // ==================================================
    always_ff @(posedge sd_datInWrite_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign pop_data = mem[rd_ptr];  // Head word, valid while level is nonzero

    assign full        = (level == LVL_W'(FIFO_DEPTH));
    assign burst_ready = (level >= LVL_W'(BURST_WORDS));    // A whole burst is stored

    // Producer must honour dat_in_ready
    a_no_push_full: assert property (@(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        push |-> !full);

    // Engine only pops inside a burst it saw as ready
    a_no_pop_empty: assert property (@(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        pop |-> (level != '0));

endmodule

/* design/readout_cmd_engine.sv */
module readout_cmd_engine #(
    parameter int FIFO_DEPTH  = sd_readout_pkg::FIFO_DEPTH_DEFAULT,
    parameter int BURST_WORDS = sd_readout_pkg::BURST_WORDS_DEFAULT
) (
    input  logic                              sd_datInWrite_clk,
    input  logic                              spi_rst_,
    input  logic                              msg_req,
    input  msg_pkg::opcode_t                  msg_op,
    input  logic [msg_pkg::MSG_ARG_W-1:0]     msg_arg,
    output logic                              msg_ack,
    output logic [msg_pkg::RESP_W-1:0]        resp,
    output logic                              resp_err,
    output logic [msg_pkg::LED_W-1:0]         led,
    input  sd_readout_pkg::access_mode_t      access_mode,
    input  logic [msg_pkg::BLOCK_CNT_W-1:0]   block_count,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0]   level,
    input  logic                              burst_ready,
    input  sd_readout_pkg::word_t             pop_data,
    output logic                              pop,
    output logic                              out_req,
    output sd_readout_pkg::word_t             out_data,
    input  logic                              out_ack
);
    localparam int LVL_W = $clog2(FIFO_DEPTH + 1);
    localparam int CNT_W = $clog2(BURST_WORDS + 1);

    typedef enum logic [2:0] {
        IDLE,
        EXEC,
        ACK_HIGH,
        BURST_WAIT,
        WORD_REQ,
        WORD_ACK
    } engine_state_t;

    engine_state_t              state;
    logic                       req_q;
    logic [CNT_W-1:0]           word_cnt;
    logic                       burst_done;
    logic                       load_word;
    logic                       op_bad;
    logic [msg_pkg::RESP_W-1:0] status_word;
    logic [msg_pkg::RESP_W-1:0] resp_next;

    // ==================================================
    // Response decode
    // ==================================================
    always_comb begin
        status_word = '0;
        status_word[msg_pkg::STATUS_MODE_LSB +: $bits(access_mode)]     = access_mode;
        status_word[msg_pkg::STATUS_BLOCKS_LSB +: msg_pkg::BLOCK_CNT_W] = block_count;
        status_word[msg_pkg::STATUS_LEVEL_LSB +: LVL_W]                 = level;
    end

    always_comb begin
        resp_next = '0;
        op_bad    = 1'b0;
        case (msg_op)
            msg_pkg::OP_ECHO:   resp_next = msg_pkg::RESP_W'(msg_arg);   // Zero-extended
            msg_pkg::OP_STATUS: resp_next = status_word;
            msg_pkg::OP_NOP, msg_pkg::OP_LED_SET, msg_pkg::OP_READOUT: resp_next = '0;
            default:            op_bad = 1'b1;
        endcase
    end

    // Pop happens on the edge that sees the word acknowledged
    assign pop        = (state == WORD_REQ) && out_ack;
    assign burst_done = (word_cnt == CNT_W'(BURST_WORDS));
    assign load_word  = ((state == BURST_WAIT) && burst_ready) ||
                        ((state == WORD_ACK) && !out_ack && !burst_done);

    // ==================================================
    // Command FSM
    // ==================================================
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            state    <= IDLE;
            req_q    <= 1'b0;
            msg_ack  <= 1'b0;
            resp_err <= 1'b0;
            led      <= '0;
            out_req  <= 1'b0;
            word_cnt <= '0;
        end else begin
            req_q <= msg_req;   // Request is acted on one cycle after it is sampled
            case (state)
                IDLE: begin
                    if (req_q) state <= EXEC;
                end
                EXEC: begin
                    resp_err <= op_bad;
                    if (msg_op == msg_pkg::OP_LED_SET) begin
                        led <= msg_arg[msg_pkg::LED_W-1:0];
                    end
                    if (msg_op == msg_pkg::OP_READOUT) begin
                        word_cnt <= '0;
                        state    <= BURST_WAIT;
                    end else begin
                        msg_ack <= 1'b1;
                        state   <= ACK_HIGH;
                    end
                end
                ACK_HIGH: begin
                    if (!req_q) begin
                        msg_ack <= 1'b0;
                        state   <= IDLE;
                    end
                end
                BURST_WAIT: begin
                    if (burst_ready) begin
                        out_req <= 1'b1;
                        state   <= WORD_REQ;
                    end
                end
                WORD_REQ: begin
                    if (out_ack) begin
                        out_req  <= 1'b0;
                        word_cnt <= word_cnt + 1'b1;
                        state    <= WORD_ACK;
                    end
                end
                WORD_ACK: begin
                    // Next word only after out_ack drops
                    if (!out_ack && burst_done) begin
                        msg_ack <= 1'b1;    // Marks the end of the burst
                        state   <= ACK_HIGH;
                    end else if (!out_ack) begin
                        out_req <= 1'b1;
                        state   <= WORD_REQ;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Response and outgoing word
    always_ff @(posedge sd_datInWrite_clk) begin
        if (state == EXEC) begin
            resp <= resp_next;
        end
        if (load_word) begin
            out_data <= pop_data;
        end
    end

    // Opcode is held for the whole request phase
    a_msg_op_stable: assert property (@(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        msg_req |=> !msg_req || $stable(msg_op));

endmodule

/* design/sd_readout_top.sv */
module sd_readout_top #(
    parameter int FIFO_DEPTH  = sd_readout_pkg::FIFO_DEPTH_DEFAULT,
    parameter int BURST_WORDS = sd_readout_pkg::BURST_WORDS_DEFAULT
) (
    input  logic                              sd_datInWrite_clk,
    input  logic                              spi_rst_,
    // SD data-in
    input  logic                              dat_in_start,
    input  logic                              dat_in_trigger,
    input  sd_readout_pkg::word_t             dat_in_data,
    output logic                              dat_in_ready,
    // Message port
    input  logic                              msg_req,
    input  msg_pkg::opcode_t                  msg_op,
    input  logic [msg_pkg::MSG_ARG_W-1:0]     msg_arg,
    output logic                              msg_ack,
    output logic [msg_pkg::RESP_W-1:0]        resp,
    output logic                              resp_err,
    output logic [msg_pkg::LED_W-1:0]         led,
    // Readout port
    output logic                              out_req,
    output sd_readout_pkg::word_t             out_data,
    input  logic                              out_ack
);
    localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

    logic                             push;
    sd_readout_pkg::word_t            push_data;
    logic                             full;
    logic                             pop;
    sd_readout_pkg::word_t            pop_data;
    logic [LVL_W-1:0]                 level;
    logic                             burst_ready;
    sd_readout_pkg::access_mode_t     access_mode;
    logic [msg_pkg::BLOCK_CNT_W-1:0]  block_count;

    // ==================================================
    // Producer, buffer, consumer
    // ==================================================
    dat_in_capture u_capture (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .dat_in_start      (dat_in_start),
        .dat_in_trigger    (dat_in_trigger),
        .dat_in_data       (dat_in_data),
        .dat_in_ready      (dat_in_ready),
        .full              (full),
        .push              (push),
        .push_data         (push_data),
        .access_mode       (access_mode),
        .block_count       (block_count)
    );

    readout_fifo #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .BURST_WORDS (BURST_WORDS)
    ) u_fifo (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .push              (push),
        .push_data         (push_data),
        .pop               (pop),
        .pop_data          (pop_data),
        .full              (full),
        .level             (level),
        .burst_ready       (burst_ready)
    );

    readout_cmd_engine #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .BURST_WORDS (BURST_WORDS)
    ) u_engine (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .msg_req           (msg_req),
        .msg_op            (msg_op),
        .msg_arg           (msg_arg),
        .msg_ack           (msg_ack),
        .resp              (resp),
        .resp_err          (resp_err),
        .led               (led),
        .access_mode       (access_mode),
        .block_count       (block_count),
        .level             (level),
        .burst_ready       (burst_ready),
        .pop_data          (pop_data),
        .pop               (pop),
        .out_req           (out_req),
        .out_data          (out_data),
        .out_ack           (out_ack)
    );

endmodule

/* tb/tb_sd_readout.sv */
module tb_sd_readout;

    localparam int BURST           = sd_readout_pkg::BURST_WORDS_DEFAULT;
    localparam int CYCLES_PER_CASE = 300;

    logic                          sd_datInWrite_clk = 1'b0;
    logic                          spi_rst_;
    logic                          dat_in_start;
    logic                          dat_in_trigger;
    sd_readout_pkg::word_t         dat_in_data;
    logic                          dat_in_ready;
    logic                          msg_req;
    msg_pkg::opcode_t              msg_op;
    logic [msg_pkg::MSG_ARG_W-1:0] msg_arg;
    logic                          msg_ack;
    logic [msg_pkg::RESP_W-1:0]    resp;
    logic                          resp_err;
    logic [msg_pkg::LED_W-1:0]     led;
    logic                          out_req;
    sd_readout_pkg::word_t         out_data;
    logic                          out_ack;

    sd_readout_pkg::word_t src_data[$];    // Words the SD source still has to deliver
    bit                    src_start[$];   // Start pulse goes with the first word of a write
    string                 case_lines[$];

    int          value_errors = 0;
    int          other_errors = 0;
    int unsigned cycle_limit  = 0;
    int unsigned cycle_count  = 0;

    sd_readout_top #(
        .FIFO_DEPTH  (sd_readout_pkg::FIFO_DEPTH_DEFAULT),
        .BURST_WORDS (sd_readout_pkg::BURST_WORDS_DEFAULT)
    ) UUT (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .dat_in_start      (dat_in_start),
        .dat_in_trigger    (dat_in_trigger),
        .dat_in_data       (dat_in_data),
        .dat_in_ready      (dat_in_ready),
        .msg_req           (msg_req),
        .msg_op            (msg_op),
        .msg_arg           (msg_arg),
        .msg_ack           (msg_ack),
        .resp              (resp),
        .resp_err          (resp_err),
        .led               (led),
        .out_req           (out_req),
        .out_data          (out_data),
        .out_ack           (out_ack)
    );

    always #10 sd_datInWrite_clk = ~sd_datInWrite_clk;

    // ==================================================
    // Watchdog and SD source
    // ==================================================
    initial begin : watchdog
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge sd_datInWrite_clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the cases did not finish", cycle_count);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : sd_source
        bit accepted;
        dat_in_start   = 1'b0;
        dat_in_trigger = 1'b0;
        dat_in_data    = '0;
        forever begin
            @(negedge sd_datInWrite_clk);
            accepted = dat_in_trigger && dat_in_ready;  // Transfer on the coming edge
            @(posedge sd_datInWrite_clk);
            #2;
            if (accepted) begin
                void'(src_data.pop_front());
                void'(src_start.pop_front());
            end
            dat_in_trigger = (src_data.size() != 0);
            dat_in_data    = (src_data.size() != 0) ? src_data[0] : '0;
            dat_in_start   = (src_start.size() != 0) ? src_start[0] : 1'b0;
        end
    end

    task automatic queue_block_words(input int count, input logic [15:0] base,
                                     input logic [3:0] mode);
        sd_readout_pkg::word_t word;
        for (int i = 0; i < count; i++) begin
            word = base + 16'(i);
            if (i % sd_readout_pkg::BLOCK_WORDS == sd_readout_pkg::ACCESS_MODE_WORD) begin
                word[sd_readout_pkg::ACCESS_MODE_LSB +: 4] = mode;
            end
            src_data.push_back(word);
            src_start.push_back(i == 0);
        end
    endtask

    // Done when every word is in, or the source is held off by a full FIFO
    task automatic wait_source_settled();
        @(negedge sd_datInWrite_clk);
        while (src_data.size() != 0 && dat_in_ready) @(negedge sd_datInWrite_clk);
    endtask

    // ==================================================
    // Message and readout handshakes
    // ==================================================
    task automatic run_command(input string name, input int op, input logic [23:0] arg,
                               input logic [31:0] exp_resp, input logic exp_err,
                               input bit is_read, input logic [15:0] first_word);
        int          nwords;
        int          ack_delay;
        logic [15:0] exp_word;
        nwords = 0;
        wait_source_settled();
        @(posedge sd_datInWrite_clk);
        #2;
        msg_op  = msg_pkg::opcode_t'(op);
        msg_arg = arg;
        msg_req = 1'b1;
        @(negedge sd_datInWrite_clk);
        while (!msg_ack) begin
            if (out_req && !out_ack) begin
                exp_word = first_word + 16'(nwords);
                if (out_data !== exp_word) begin
                    value_errors++;
                    $display("Error: %s word %0d expected %h actual %h",
                             name, nwords, exp_word, out_data);
                end
                nwords++;
                ack_delay = $urandom % 4;   // Slow consumer, 0 to 3 cycles
                repeat (ack_delay) @(posedge sd_datInWrite_clk);
                @(posedge sd_datInWrite_clk);
                #2 out_ack = 1'b1;
                @(negedge sd_datInWrite_clk);
                while (out_req) @(negedge sd_datInWrite_clk);
                @(posedge sd_datInWrite_clk);
                #2 out_ack = 1'b0;
            end
            @(negedge sd_datInWrite_clk);
        end
        if (resp !== exp_resp) begin
            value_errors++;
            $display("Error: %s resp expected %h actual %h", name, exp_resp, resp);
        end
        if (resp_err !== exp_err) begin
            value_errors++;
            $display("Error: %s resp_err expected %b actual %b", name, exp_err, resp_err);
        end
        if (nwords != (is_read ? BURST : 0)) begin
            value_errors++;
            $display("Error: %s word count expected %0d actual %0d",
                     name, is_read ? BURST : 0, nwords);
        end
        if (op == 2 && led !== arg[msg_pkg::LED_W-1:0]) begin
            value_errors++;
            $display("Error: %s led expected %h actual %h", name, arg[3:0], led);
        end
        @(posedge sd_datInWrite_clk);
        #2 msg_req = 1'b0;
        @(negedge sd_datInWrite_clk);
        while (msg_ack) @(negedge sd_datInWrite_clk);
    endtask

    task automatic read_case_file();
        int    fd;
        string line;
        string kind;
        fd = $fopen("tb/sd_readout_cases.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the case file tb/sd_readout_cases.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line[line.len()-1] == "\n") begin
                    line = line.substr(0, line.len() - 2);
                end
                if ($sscanf(line, "%s", kind) == 1 && kind[0] != "#") begin
                    case_lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin : main_sequence
        string       kind;
        string       name;
        int          count;
        int          op;
        int          err_flag;
        int          fields;
        logic [15:0] base;
        logic [15:0] first;
        logic [3:0]  mode;
        logic [23:0] arg;
        logic [31:0] exp_resp;

        void'($urandom(32'h73aa));
        spi_rst_ = 1'b0;
        msg_req  = 1'b0;
        msg_op   = msg_pkg::OP_NOP;
        msg_arg  = '0;
        out_ack  = 1'b0;
        read_case_file();
        cycle_limit = CYCLES_PER_CASE * (case_lines.size() + 1);

        repeat (4) @(posedge sd_datInWrite_clk);
        #2 spi_rst_ = 1'b1;
        @(negedge sd_datInWrite_clk);
        if (msg_ack !== 1'b0 || out_req !== 1'b0 || resp_err !== 1'b0 ||
            led !== '0 || dat_in_ready !== 1'b1) begin
            other_errors++;
            $display("Outputs are not at their reset values after reset");
        end

        foreach (case_lines[i]) begin
            fields = $sscanf(case_lines[i], "%s", kind);
            if (kind == "write") begin
                fields = $sscanf(case_lines[i], "%s %d %h %h", kind, count, base, mode);
                if (fields == 4) begin
                    queue_block_words(count, base, mode);
                    wait_source_settled();
                end else begin
                    other_errors++;
                    $display("Malformed case line: %s", case_lines[i]);
                end
            end else if (kind == "cmd") begin
                fields = $sscanf(case_lines[i], "%s %s %d %h %h %d",
                                 kind, name, op, arg, exp_resp, err_flag);
                if (fields == 6) begin
                    run_command(name, op, arg, exp_resp, err_flag != 0, 1'b0, '0);
                end else begin
                    other_errors++;
                    $display("Malformed case line: %s", case_lines[i]);
                end
            end else if (kind == "read") begin
                fields = $sscanf(case_lines[i], "%s %s %h", kind, name, first);
                if (fields == 3) begin
                    run_command(name, 4, '0, '0, 1'b0, 1'b1, first);
                end else begin
                    other_errors++;
                    $display("Malformed case line: %s", case_lines[i]);
                end
            end else begin
                other_errors++;
                $display("Unknown kind of case in line: %s", case_lines[i]);
            end
        end

        repeat (2) @(posedge sd_datInWrite_clk);
        $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tb/sd_readout_cases.txt */
# write <words> <base hex> <mode hex>: words are base+i, word 8 of each block holds mode in 11:8
# cmd <name> <op> <arg hex> <resp hex> <err>, read <name> <first word hex> for one whole burst
cmd echo_small 1 a5c3e1 00a5c3e1 0
cmd echo_ones 1 ffffff 00ffffff 0
cmd led_set 2 00003b 00000000 0
cmd nop 0 123456 00000000 0
cmd status_reset 3 000000 00000000 0
write 32 0500 5
cmd status_block 3 000000 00020015 0
read readout_first 0500
cmd status_after_read 3 000000 00010015 0
write 60 0a00 a
cmd status_full 3 000000 0004002a 0
read readout_held 0510
cmd status_refill 3 000000 0003c02a 0
read readout_next 0a00
read readout_next2 0a10
read readout_next3 0a20
cmd status_drained 3 000000 0000c02a 0
cmd bad_opcode 5 000042 00000000 1

/* build.f */
design/sd_readout_pkg.sv
design/msg_pkg.sv
design/dat_in_capture.sv
design/readout_fifo.sv
design/readout_cmd_engine.sv
design/sd_readout_top.sv
tb/tb_sd_readout.sv
